// File: source/wb_defines.svh
`ifndef WB_DEFINES_SVH
`define WB_DEFINES_SVH

// datapath and register file
`define XLEN 32
`define NUM_REGS 16

// transaction ids, so eight in flight at most
`define ID_W 3

// write-back sizing
`define NUM_WB_UNITS 2
`define WRITEBACK_BUFFERS 2

// multiplier iterations, one byte of multiplier per step
`define MUL_STEPS 4

`endif

// File: source/core_types_pkg.sv
`include "wb_defines.svh"

package core_types_pkg;

    typedef logic [`ID_W-1:0] id_t;
    typedef logic [$clog2(`NUM_REGS)-1:0] reg_addr_t;

    // function codes
    // mul is the only one routed to the multiplier
    typedef enum logic [2:0] {
        fn_add = 3'd0,
        fn_sub = 3'd1,
        fn_xor = 3'd2,
        fn_sll = 3'd3,
        fn_mul = 3'd4
    } funct_e;

    // register-register format, fmt = 0
    typedef struct packed {
        logic fmt;
        funct_e funct;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic [15:0] unused;
    } rr_instr_t;

    // register-immediate format, fmt = 1
    typedef struct packed {
        logic fmt;
        funct_e funct;
        reg_addr_t rd;
        reg_addr_t rs1;
        logic signed [19:0] imm;
    } ri_instr_t;

    // bit 31 picks the reading
    typedef union packed {
        rr_instr_t rr;
        ri_instr_t ri;
    } instr_u;

endpackage

// File: source/wb_types_pkg.sv
`include "wb_defines.svh"

package wb_types_pkg;

    // one commit buffer slot
    typedef struct packed {
        logic [`XLEN-1:0] rd;
        core_types_pkg::id_t id;
    } commit_buffer_t;

    typedef logic [$clog2(`NUM_WB_UNITS)-1:0] unit_idx_t;

    // lower index wins the ack
    localparam unit_idx_t alu_idx = 1'b0;
    localparam unit_idx_t mul_idx = 1'b1;

endpackage

// File: source/wb_interfaces.sv
`include "wb_defines.svh"

// result handoff from one execution unit
interface unit_writeback_if;
    logic done;
    core_types_pkg::id_t id;
    logic [`XLEN-1:0] rd;
    logic ack;

    modport unit (output done, id, rd, input ack);
    modport wb (input done, id, rd, output ack);
endinterface

// retirement to the register file plus operand bypass to issue
interface rf_writeback_if;
    logic retiring;
    core_types_pkg::id_t id;
    logic [`XLEN-1:0] rd_data;

    // pending ids looked up by issue
    core_types_pkg::id_t rs1_id;
    core_types_pkg::id_t rs2_id;

    // bypass answers from the commit buffer
    logic rs1_valid;
    logic [`XLEN-1:0] rs1_data;
    logic rs2_valid;
    logic [`XLEN-1:0] rs2_data;

    modport writeback (
        output retiring, id, rd_data, rs1_valid, rs1_data, rs2_valid, rs2_data,
        input rs1_id, rs2_id
    );
    modport regfile (input retiring, id, rd_data);
    modport issue (
        output rs1_id, rs2_id,
        input rs1_valid, rs1_data, rs2_valid, rs2_data
    );
endinterface

// File: source/issue_stage.sv
`include "wb_defines.svh"

module issue_stage (
    input logic clk,
    input logic rst,
    input logic instr_valid,
    input core_types_pkg::instr_u instr_word,
    output logic instr_ready,
    rf_writeback_if.issue rf_wb,
    output core_types_pkg::reg_addr_t rs1_addr,
    output core_types_pkg::reg_addr_t rs2_addr,
    input logic [`XLEN-1:0] rs1_reg,
    input logic [`XLEN-1:0] rs2_reg,
    input logic rs1_pending,
    input logic rs2_pending,
    input core_types_pkg::id_t rs1_pend_id,
    input core_types_pkg::id_t rs2_pend_id,
    output logic claim,
    output core_types_pkg::reg_addr_t claim_rd,
    output core_types_pkg::id_t claim_id,
    input logic retired,
    input logic single_cycle_issue_possible,
    output logic alu_start,
    output logic mul_start,
    output core_types_pkg::id_t issue_id,
    output core_types_pkg::funct_e issue_funct,
    output logic [`XLEN-1:0] op_a,
    output logic [`XLEN-1:0] op_b,
    input logic alu_busy,
    input logic mul_busy
);
    localparam int MAX_IN_FLIGHT = 2 ** `ID_W;

    logic is_imm;
    logic is_mul;
    logic [`XLEN-1:0] imm_ext;
    logic rs1_ok;
    logic rs2_ok;
    logic unit_free;
    logic accept;
    core_types_pkg::id_t next_id;
    logic [`ID_W:0] in_flight;

    ////////////////////////////////////////
    // decode
    // fmt, funct, rd and rs1 sit at the same bits in both readings
    assign is_imm = instr_word.ri.fmt;
    assign is_mul = (instr_word.rr.funct == core_types_pkg::fn_mul);
    assign imm_ext = {{(`XLEN-20){instr_word.ri.imm[19]}}, instr_word.ri.imm};

    assign rs1_addr = instr_word.rr.rs1;
    assign rs2_addr = instr_word.rr.rs2;

    ////////////////////////////////////////
    // operands
    // pending ids go to write-back for the bypass lookup
    assign rf_wb.rs1_id = rs1_pend_id;
    assign rf_wb.rs2_id = rs2_pend_id;

    assign op_a = rs1_pending ? rf_wb.rs1_data : rs1_reg;
    assign op_b = is_imm ? imm_ext : (rs2_pending ? rf_wb.rs2_data : rs2_reg);

    // source usable if not pending or already in the commit buffer
    assign rs1_ok = ~rs1_pending | rf_wb.rs1_valid;
    // rs2 field is part of the immediate in ri format
    assign rs2_ok = is_imm | ~rs2_pending | rf_wb.rs2_valid;

    ////////////////////////////////////////
    // stall and dispatch
    // alu results need a free commit slot next cycle
    assign unit_free = is_mul ? ~mul_busy : (~alu_busy & single_cycle_issue_possible);
    assign instr_ready = ~rst & rs1_ok & rs2_ok & unit_free & (in_flight != MAX_IN_FLIGHT);
    assign accept = instr_valid & instr_ready;

    assign alu_start = accept & ~is_mul;
    assign mul_start = accept & is_mul;
    assign issue_id = next_id;
    assign issue_funct = instr_word.rr.funct;

    // r0 is never marked pending
    assign claim = accept & (instr_word.rr.rd != '0);
    assign claim_rd = instr_word.rr.rd;
    assign claim_id = next_id;

    // ids handed out in order, modulo 8
    always_ff @(posedge clk) begin
        if (rst) begin
            next_id <= '0;
            in_flight <= '0;
        end else begin
            if (accept)
                next_id <= next_id + 1'b1;
            in_flight <= in_flight + (`ID_W+1)'(accept) - (`ID_W+1)'(retired);
        end
    end

    // units report busy until their held result is acked
    assert property (@(posedge clk) disable iff (rst)
        !(alu_start && alu_busy) && !(mul_start && mul_busy));

endmodule

// File: source/alu_unit.sv
`include "wb_defines.svh"

module alu_unit (
    input logic clk,
    input logic rst,
    input logic start,
    input core_types_pkg::id_t id,
    input core_types_pkg::funct_e funct,
    input logic [`XLEN-1:0] a,
    input logic [`XLEN-1:0] b,
    output logic busy,
    unit_writeback_if.unit wb
);
    logic [`XLEN-1:0] result;
    logic [`XLEN-1:0] rd_r;
    core_types_pkg::id_t id_r;
    logic done_r;

    // single-cycle ops
    always_comb begin
        case (funct)
            core_types_pkg::fn_sub: result = a - b;
            core_types_pkg::fn_xor: result = a ^ b;
            core_types_pkg::fn_sll: result = a << b[4:0];
            default: result = a + b;
        endcase
    end

    // done set by start, cleared by ack
    always_ff @(posedge clk) begin
        if (rst)
            done_r <= 1'b0;
        else if (start)
            done_r <= 1'b1;
        else if (wb.ack)
            done_r <= 1'b0;
    end

    // result held until write-back takes it
    always_ff @(posedge clk) begin
        if (start) begin
            rd_r <= result;
            id_r <= id;
        end
    end

    assign wb.done = done_r;
    assign wb.id = id_r;
    assign wb.rd = rd_r;
    // an ack this cycle frees the unit for a back-to-back start
    assign busy = done_r & ~wb.ack;

endmodule

// File: source/mul_unit.sv
`include "wb_defines.svh"

module mul_unit (
    input logic clk,
    input logic rst,
    input logic start,
    input core_types_pkg::id_t id,
    input core_types_pkg::funct_e funct,
    input logic [`XLEN-1:0] a,
    input logic [`XLEN-1:0] b,
    output logic busy,
    unit_writeback_if.unit wb
);
    localparam int STEP_W = $clog2(`MUL_STEPS);
    localparam int SLICE = `XLEN / `MUL_STEPS;

    logic running;
    logic done_r;
    logic [STEP_W-1:0] step;
    logic [`XLEN-1:0] mcand;
    logic [`XLEN-1:0] mplier;
    logic [`XLEN-1:0] acc;
    core_types_pkg::id_t id_r;

    ////////////////////////////////////////
    // control
    // operands load on start, then MUL_STEPS iterations
    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            done_r <= 1'b0;
            step <= '0;
        end else begin
            if (wb.ack)
                done_r <= 1'b0;
            if (start) begin
                running <= 1'b1;
                step <= '0;
            end else if (running) begin
                step <= step + 1'b1;
                // last slice lands with done
                if (step == STEP_W'(`MUL_STEPS - 1)) begin
                    running <= 1'b0;
                    done_r <= 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////
    // shift-add datapath
    // one multiplier byte per cycle, low XLEN bits kept
    always_ff @(posedge clk) begin
        if (start) begin
            mcand <= a;
            mplier <= b;
            acc <= '0;
            id_r <= id;
        end else if (running) begin
            acc <= acc + mcand * mplier[SLICE-1:0];
            mcand <= mcand << SLICE;
            mplier <= mplier >> SLICE;
        end
    end

    assign wb.done = done_r;
    assign wb.id = id_r;
    assign wb.rd = acc;
    assign busy = running | (done_r & ~wb.ack);

    // result stays up until write-back takes it
    assert property (@(posedge clk) disable iff (rst)
        wb.done && !wb.ack |=> wb.done);

endmodule

// File: source/write_back.sv
`include "wb_defines.svh"

module write_back (
    input logic clk,
    input logic rst,
    unit_writeback_if.wb unit_wb [`NUM_WB_UNITS],
    rf_writeback_if.writeback rf_wb,
    output logic retired,
    output core_types_pkg::id_t retired_id,
    output logic single_cycle_issue_possible
);
    localparam int BUF_IDX_W = $clog2(`WRITEBACK_BUFFERS);
    localparam int CNT_W = $clog2(`NUM_WB_UNITS + `WRITEBACK_BUFFERS) + 1;

    logic unit_done [`NUM_WB_UNITS];
    logic unit_ack [`NUM_WB_UNITS];
    core_types_pkg::id_t unit_id [`NUM_WB_UNITS];
    logic [`XLEN-1:0] unit_rd [`NUM_WB_UNITS];

    wb_types_pkg::commit_buffer_t commit_buffer [`WRITEBACK_BUFFERS];
    logic buf_valid [`WRITEBACK_BUFFERS];
    logic buf_ready [`WRITEBACK_BUFFERS];
    logic buf_write [`WRITEBACK_BUFFERS];
    wb_types_pkg::unit_idx_t buf_sel [`WRITEBACK_BUFFERS];
    logic [BUF_IDX_W-1:0] retire_idx;

    logic [CNT_W-1:0] multi_done;
    logic [CNT_W-1:0] ready_cnt;

    logic [`WRITEBACK_BUFFERS-1:0] rs1_match;
    logic [`WRITEBACK_BUFFERS-1:0] rs2_match;
    logic [BUF_IDX_W-1:0] rs1_sel;
    logic [BUF_IDX_W-1:0] rs2_sel;

    // flatten the interface array so it can be indexed by a variable
    for (genvar u = 0; u < `NUM_WB_UNITS; u++) begin : g_unit
        assign unit_done[u] = unit_wb[u].done;
        assign unit_id[u] = unit_wb[u].id;
        assign unit_rd[u] = unit_wb[u].rd;
        assign unit_wb[u].ack = unit_ack[u];

        // an ack lands in the buffer and retires the cycle after
        assert property (@(posedge clk) disable iff (rst)
            unit_ack[u] |-> unit_done[u] ##1 retired);
    end

    ////////////////////////////////////////
    // retire slot and ready slots
    // lowest valid slot retires
    always_comb begin
        retire_idx = '0;
        for (int i = `WRITEBACK_BUFFERS - 1; i >= 0; i--) begin
            if (buf_valid[i])
                retire_idx = BUF_IDX_W'(i);
        end
    end

    // the retiring slot empties this cycle, so it can take new data
    always_comb begin
        for (int i = 0; i < `WRITEBACK_BUFFERS; i++)
            buf_ready[i] = ~buf_valid[i];
        buf_ready[retire_idx] = 1'b1;
    end

    ////////////////////////////////////////
    // ack arbitration
    // each slot takes the lowest-index done unit not yet acked
    always_comb begin
        unit_ack = '{default: 1'b0};
        buf_write = '{default: 1'b0};
        buf_sel = '{default: '0};
        for (int i = 0; i < `WRITEBACK_BUFFERS; i++) begin
            for (int u = 0; u < `NUM_WB_UNITS; u++) begin
                if (unit_done[u] & ~unit_ack[u] & ~buf_write[i]) begin
                    buf_sel[i] = wb_types_pkg::unit_idx_t'(u);
                    unit_ack[u] = buf_ready[i];
                    buf_write[i] = buf_ready[i];
                end
            end
        end
    end

    // an alu issued now is safe when ready slots outnumber waiting multi-cycle results
    always_comb begin
        multi_done = '0;
        for (int u = 0; u < `NUM_WB_UNITS; u++) begin
            if (u != int'(wb_types_pkg::alu_idx))
                multi_done += CNT_W'(unit_done[u]);
        end
        ready_cnt = '0;
        for (int i = 0; i < `WRITEBACK_BUFFERS; i++)
            ready_cnt += CNT_W'(buf_ready[i]);
    end
    assign single_cycle_issue_possible = (ready_cnt > multi_done);

    ////////////////////////////////////////
    // commit buffer
    always_ff @(posedge clk) begin
        for (int i = 0; i < `WRITEBACK_BUFFERS; i++) begin
            if (rst)
                buf_valid[i] <= 1'b0;
            else
                buf_valid[i] <= buf_write[i] | (buf_valid[i] & ~buf_ready[i]);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `WRITEBACK_BUFFERS; i++) begin
            if (buf_ready[i]) begin
                commit_buffer[i].rd <= unit_rd[buf_sel[i]];
                commit_buffer[i].id <= unit_id[buf_sel[i]];
            end
        end
    end

    ////////////////////////////////////////
    // retirement and bypass
    always_comb begin
        retired = 1'b0;
        rs1_sel = '0;
        rs2_sel = '0;
        for (int i = 0; i < `WRITEBACK_BUFFERS; i++) begin
            retired |= buf_valid[i];
            rs1_match[i] = buf_valid[i] && (commit_buffer[i].id == rf_wb.rs1_id);
            rs2_match[i] = buf_valid[i] && (commit_buffer[i].id == rf_wb.rs2_id);
            if (rs1_match[i])
                rs1_sel = BUF_IDX_W'(i);
            if (rs2_match[i])
                rs2_sel = BUF_IDX_W'(i);
        end
    end

    assign retired_id = commit_buffer[retire_idx].id;

    assign rf_wb.retiring = retired;
    assign rf_wb.id = retired_id;
    assign rf_wb.rd_data = commit_buffer[retire_idx].rd;

    assign rf_wb.rs1_valid = |rs1_match;
    assign rf_wb.rs2_valid = |rs2_match;
    assign rf_wb.rs1_data = commit_buffer[rs1_sel].rd;
    assign rf_wb.rs2_data = commit_buffer[rs2_sel].rd;

endmodule

// File: source/register_file.sv
`include "wb_defines.svh"

module register_file (
    input logic clk,
    input logic rst,
    rf_writeback_if.regfile rf_wb,
    input core_types_pkg::reg_addr_t rs1_addr,
    input core_types_pkg::reg_addr_t rs2_addr,
    output logic [`XLEN-1:0] rs1_reg,
    output logic [`XLEN-1:0] rs2_reg,
    output logic rs1_pending,
    output logic rs2_pending,
    output core_types_pkg::id_t rs1_pend_id,
    output core_types_pkg::id_t rs2_pend_id,
    input logic claim,
    input core_types_pkg::reg_addr_t claim_rd,
    input core_types_pkg::id_t claim_id,
    input core_types_pkg::reg_addr_t dbg_addr,
    output logic [`XLEN-1:0] dbg_data
);
    logic [`XLEN-1:0] regs [`NUM_REGS];
    logic pend [`NUM_REGS];
    core_types_pkg::id_t pend_id [`NUM_REGS];
    // retirement names only an id
    core_types_pkg::reg_addr_t id_to_rd [2**`ID_W];

    core_types_pkg::reg_addr_t ret_rd;
    logic ret_write;

    // write only if this id is still the newest writer of rd
    assign ret_rd = id_to_rd[rf_wb.id];
    assign ret_write = rf_wb.retiring && pend[ret_rd] && (pend_id[ret_rd] == rf_wb.id);

    ////////////////////////////////////////
    // values and pending bits
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < `NUM_REGS; r++) begin
                regs[r] <= '0;
                pend[r] <= 1'b0;
            end
        end else begin
            if (ret_write) begin
                regs[ret_rd] <= rf_wb.rd_data;
                pend[ret_rd] <= 1'b0;
            end
            // a same-cycle claim overrides the clear
            if (claim)
                pend[claim_rd] <= 1'b1;
        end
    end

    // claim records the new owner both ways
    always_ff @(posedge clk) begin
        if (claim) begin
            pend_id[claim_rd] <= claim_id;
            id_to_rd[claim_id] <= claim_rd;
        end
    end

    ////////////////////////////////////////
    // read ports, r0 hardwired
    assign rs1_reg = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_reg = (rs2_addr == '0) ? '0 : regs[rs2_addr];
    assign rs1_pending = pend[rs1_addr];
    assign rs2_pending = pend[rs2_addr];
    assign rs1_pend_id = pend_id[rs1_addr];
    assign rs2_pend_id = pend_id[rs2_addr];
    assign dbg_data = (dbg_addr == '0) ? '0 : regs[dbg_addr];

endmodule

// File: source/wb_subsystem.sv
`include "wb_defines.svh"

module wb_subsystem (
    input logic clk,
    input logic rst,
    input logic instr_valid,
    input core_types_pkg::instr_u instr_word,
    output logic instr_ready,
    output logic retired,
    output core_types_pkg::id_t retired_id,
    input core_types_pkg::reg_addr_t dbg_addr,
    output logic [`XLEN-1:0] dbg_data
);
    unit_writeback_if unit_wb [`NUM_WB_UNITS] ();
    rf_writeback_if rf_wb ();

    // scoreboard and operand reads
    core_types_pkg::reg_addr_t rs1_addr;
    core_types_pkg::reg_addr_t rs2_addr;
    logic [`XLEN-1:0] rs1_reg;
    logic [`XLEN-1:0] rs2_reg;
    logic rs1_pending;
    logic rs2_pending;
    core_types_pkg::id_t rs1_pend_id;
    core_types_pkg::id_t rs2_pend_id;
    logic claim;
    core_types_pkg::reg_addr_t claim_rd;
    core_types_pkg::id_t claim_id;

    // issue port to the units
    logic alu_start;
    logic mul_start;
    core_types_pkg::id_t issue_id;
    core_types_pkg::funct_e issue_funct;
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic alu_busy;
    logic mul_busy;
    logic single_cycle_issue_possible;

    ////////////////////////////////////////
    // issue
    issue_stage issue0 (
        .clk(clk),
        .rst(rst),
        .instr_valid(instr_valid),
        .instr_word(instr_word),
        .instr_ready(instr_ready),
        .rf_wb(rf_wb),
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .rs1_reg(rs1_reg),
        .rs2_reg(rs2_reg),
        .rs1_pending(rs1_pending),
        .rs2_pending(rs2_pending),
        .rs1_pend_id(rs1_pend_id),
        .rs2_pend_id(rs2_pend_id),
        .claim(claim),
        .claim_rd(claim_rd),
        .claim_id(claim_id),
        .retired(retired),
        .single_cycle_issue_possible(single_cycle_issue_possible),
        .alu_start(alu_start),
        .mul_start(mul_start),
        .issue_id(issue_id),
        .issue_funct(issue_funct),
        .op_a(op_a),
        .op_b(op_b),
        .alu_busy(alu_busy),
        .mul_busy(mul_busy)
    );

    ////////////////////////////////////////
    // execute
    alu_unit alu0 (
        .clk(clk),
        .rst(rst),
        .start(alu_start),
        .id(issue_id),
        .funct(issue_funct),
        .a(op_a),
        .b(op_b),
        .busy(alu_busy),
        .wb(unit_wb[wb_types_pkg::alu_idx])
    );

    mul_unit mul0 (
        .clk(clk),
        .rst(rst),
        .start(mul_start),
        .id(issue_id),
        .funct(issue_funct),
        .a(op_a),
        .b(op_b),
        .busy(mul_busy),
        .wb(unit_wb[wb_types_pkg::mul_idx])
    );

    ////////////////////////////////////////
    // write-back and register file
    write_back wb0 (
        .clk(clk),
        .rst(rst),
        .unit_wb(unit_wb),
        .rf_wb(rf_wb),
        .retired(retired),
        .retired_id(retired_id),
        .single_cycle_issue_possible(single_cycle_issue_possible)
    );

    register_file rf0 (
        .clk(clk),
        .rst(rst),
        .rf_wb(rf_wb),
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .rs1_reg(rs1_reg),
        .rs2_reg(rs2_reg),
        .rs1_pending(rs1_pending),
        .rs2_pending(rs2_pending),
        .rs1_pend_id(rs1_pend_id),
        .rs2_pend_id(rs2_pend_id),
        .claim(claim),
        .claim_rd(claim_rd),
        .claim_id(claim_id),
        .dbg_addr(dbg_addr),
        .dbg_data(dbg_data)
    );

endmodule

// File: test/wb_subsystem_tb.sv
`include "wb_defines.svh"

module wb_subsystem_tb;

    localparam int TBL_LEN = 60;
    localparam int N_RAND = 40;
    localparam int LIMIT = TBL_LEN * 12 + 100;
    // ALU done next cycle, retire one cycle later
    localparam int ALU_LAT = 2;
    // operand load, MUL_STEPS iterations, then the buffer cycle
    localparam int MUL_LAT = `MUL_STEPS + 2;

    // function codes as the instruction word carries them
    localparam logic [2:0] F_ADD = 3'd0;
    localparam logic [2:0] F_SUB = 3'd1;
    localparam logic [2:0] F_XOR = 3'd2;
    localparam logic [2:0] F_SLL = 3'd3;
    localparam logic [2:0] F_MUL = 3'd4;

    // one table row with word, expected rd value, expected latency and flags
    typedef struct packed {
        logic [31:0] word;
        logic [31:0] exp;
        logic [3:0] lat;
        logic chk;
        logic full;
        logic early;
    } entry_t;

    logic clk;
    logic rst;
    logic instr_valid;
    logic [31:0] instr_word;
    logic instr_ready;
    logic retired;
    logic [`ID_W-1:0] retired_id;
    logic [3:0] dbg_addr;
    logic [`XLEN-1:0] dbg_data;

    entry_t tbl [0:TBL_LEN-1];
    int n_entries = 0;
    logic [31:0] shadow [0:`NUM_REGS-1];
    int accept_cyc [0:TBL_LEN-1];
    bit done_flag [0:TBL_LEN-1];
    int outstanding [$];
    int n_acc = 0;
    int n_ret = 0;
    int cycles = 0;
    int n_checks = 0;
    int n_errors = 0;
    logic [31:0] lfsr_state = 32'he20d_82d3;

    wb_subsystem dut0 (
        .clk(clk),
        .rst(rst),
        .instr_valid(instr_valid),
        .instr_word(instr_word),
        .instr_ready(instr_ready),
        .retired(retired),
        .retired_id(retired_id),
        .dbg_addr(dbg_addr),
        .dbg_data(dbg_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////
    // helpers

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        logic fb;
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    // register-register word, low 16 bits unused
    function automatic logic [31:0] enc_rr(input logic [2:0] fn, input logic [3:0] rd,
                                           input logic [3:0] rs1, input logic [3:0] rs2);
        return {1'b0, fn, rd, rs1, rs2, 16'h0000};
    endfunction

    // register-immediate word, 20-bit signed immediate
    function automatic logic [31:0] enc_ri(input logic [2:0] fn, input logic [3:0] rd,
                                           input logic [3:0] rs1, input logic [19:0] imm);
        return {1'b1, fn, rd, rs1, imm};
    endfunction

    // function rules
    function automatic logic [31:0] ref_alu(input logic [2:0] fn, input logic [31:0] a,
                                            input logic [31:0] b);
        case (fn)
            F_ADD: return a + b;
            F_SUB: return a - b;
            F_XOR: return a ^ b;
            F_SLL: return a << b[4:0];
            F_MUL: return a * b;
            default: return 32'h0;
        endcase
    endfunction

    task automatic add_entry(input logic [31:0] word, input logic [3:0] lat, input logic chk,
                             input logic [31:0] exp, input logic early, input logic full);
        tbl[n_entries] = {word, exp, lat, chk, full, early};
        n_entries++;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    // program-order model, r0 stays zero
    task automatic update_shadow(input logic [31:0] w);
        logic [31:0] a;
        logic [31:0] b;
        a = shadow[w[23:20]];
        b = w[31] ? {{12{w[19]}}, w[19:0]} : shadow[w[19:16]];
        if (w[27:24] != 4'd0)
            shadow[w[27:24]] = ref_alu(w[30:28], a, b);
    endtask

    // hold the word until accepted, leave at the next edge plus 10
    task automatic issue_word(input logic [31:0] w);
        instr_valid = 1'b1;
        instr_word = w;
        @(negedge clk);
        while (!instr_ready)
            @(negedge clk);
        @(posedge clk);
        #10;
        instr_valid = 1'b0;
    endtask

    task automatic wait_idle();
        do begin
            @(posedge clk);
            #10;
        end while (outstanding.size() != 0);
    endtask

    task automatic check_regs();
        int r;
        for (r = 0; r < `NUM_REGS; r++) begin
            dbg_addr = 4'(r);
            @(negedge clk);
            check_value($sformatf("dbg_data r%0d", r), dbg_data, shadow[r]);
            @(posedge clk);
            #10;
        end
    endtask

    ////////////////////////////////////////
    // monitor of acceptance and retirement

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout: run did not complete within %0d cycles", LIMIT);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    always @(negedge clk) begin : monitor
        int k;
        int s;
        int hit;
        if (!rst) begin
            // retirement first, a new id never matches one retiring
            if (retired) begin
                hit = -1;
                for (k = 0; k < outstanding.size(); k++) begin
                    if (outstanding[k] % (1 << `ID_W) == int'(retired_id))
                        hit = k;
                end
                if (hit < 0) begin
                    n_errors++;
                    $display("retired id %0d does not belong to any instruction in flight",
                             retired_id);
                end else begin
                    s = outstanding[hit];
                    outstanding.delete(hit);
                    done_flag[s] = 1'b1;
                    n_ret++;
                    if (tbl[s].lat != 0)
                        check_value("latency", 32'(cycles - accept_cyc[s]), 32'(tbl[s].lat));
                    // the ALU op after a multiply must already be out
                    if (s + 1 < n_entries && tbl[s + 1].early && !done_flag[s + 1]) begin
                        n_errors++;
                        $display("multiply of entry %0d retired before the ALU op after it", s);
                    end
                end
            end
            if (instr_valid && instr_ready) begin
                update_shadow(instr_word);
                accept_cyc[n_acc] = cycles;
                outstanding.push_back(n_acc);
                n_acc++;
            end
        end
    end

    ////////////////////////////////////////
    // stimulus table and run

    initial begin : run
        int i;
        logic [31:0] fn;
        logic [31:0] rd;
        logic [31:0] rs1;
        logic [31:0] fmt;
        logic [31:0] src;
        logic [31:0] w;

        rst = 1'b1;
        instr_valid = 1'b0;
        instr_word = '0;
        dbg_addr = '0;
        for (i = 0; i < `NUM_REGS; i++)
            shadow[i] = '0;

        // each function in both formats, isolated so latency is fixed
        add_entry(enc_ri(F_ADD, 4'd1, 4'd0, 20'd100), ALU_LAT, 1, 32'd100, 0, 0);
        add_entry(enc_ri(F_SUB, 4'd2, 4'd0, 20'd7), ALU_LAT, 1, 32'hffff_fff9, 0, 0);
        add_entry(enc_ri(F_XOR, 4'd3, 4'd1, 20'h000ff), ALU_LAT, 1, 32'h0000_009b, 0, 0);
        add_entry(enc_ri(F_SLL, 4'd4, 4'd1, 20'd3), ALU_LAT, 1, 32'h0000_0320, 0, 0);
        add_entry(enc_ri(F_MUL, 4'd5, 4'd1, 20'hffffd), MUL_LAT, 1, 32'hffff_fed4, 0, 0);
        add_entry(enc_rr(F_ADD, 4'd6, 4'd1, 4'd2), ALU_LAT, 1, 32'h0000_005d, 0, 0);
        add_entry(enc_rr(F_SUB, 4'd7, 4'd1, 4'd4), ALU_LAT, 1, 32'hffff_fd44, 0, 0);
        add_entry(enc_rr(F_XOR, 4'd8, 4'd2, 4'd3), ALU_LAT, 1, 32'hffff_ff62, 0, 0);
        add_entry(enc_rr(F_SLL, 4'd9, 4'd3, 4'd1), ALU_LAT, 1, 32'h0000_09b0, 0, 0);
        add_entry(enc_rr(F_MUL, 4'd10, 4'd4, 4'd5), MUL_LAT, 1, 32'hfffc_5680, 0, 0);
        add_entry(enc_rr(F_MUL, 4'd11, 4'd2, 4'd2), MUL_LAT, 1, 32'h0000_0031, 0, 0);

        // back-to-back dependencies through both units
        add_entry(enc_ri(F_ADD, 4'd12, 4'd1, 20'd1), 0, 0, 0, 0, 0);
        add_entry(enc_rr(F_ADD, 4'd13, 4'd12, 4'd12), 0, 0, 0, 0, 0);
        add_entry(enc_ri(F_MUL, 4'd14, 4'd13, 20'd3), 0, 0, 0, 0, 0);
        add_entry(enc_rr(F_SUB, 4'd15, 4'd14, 4'd1), 0, 0, 0, 0, 0);
        add_entry(enc_rr(F_MUL, 4'd12, 4'd15, 4'd15), 0, 0, 0, 0, 0);

        // out-of-order retirement, then a stale multiply to r3
        add_entry(enc_ri(F_MUL, 4'd5, 4'd1, 20'd5), 0, 0, 0, 0, 0);
        add_entry(enc_ri(F_ADD, 4'd9, 4'd0, 20'h00055), 0, 0, 0, 1, 0);
        add_entry(enc_ri(F_MUL, 4'd3, 4'd2, 20'd9), 0, 0, 0, 0, 0);
        add_entry(enc_ri(F_ADD, 4'd3, 4'd0, 20'h00123), 0, 1, 32'h0000_0123, 1, 1);

        // random section, fields in a fixed draw order
        for (i = 0; i < N_RAND; i++) begin
            fn = lfsr_bits(3) % 5;
            rd = lfsr_bits(4);
            rs1 = lfsr_bits(4);
            fmt = lfsr_bits(1);
            if (fmt[0]) begin
                src = lfsr_bits(20);
                w = enc_ri(fn[2:0], rd[3:0], rs1[3:0], src[19:0]);
            end else begin
                src = lfsr_bits(4);
                w = enc_rr(fn[2:0], rd[3:0], rs1[3:0], src[3:0]);
            end
            add_entry(w, 0, 0, 0, 0, i == N_RAND - 1);
        end

        // no retirement and no ready during reset
        repeat (10) begin
            @(negedge clk);
            check_value("retired", 32'(retired), 32'h0);
            check_value("instr_ready", 32'(instr_ready), 32'h0);
        end
        @(posedge clk);
        #10;
        rst = 1'b0;
        @(negedge clk);
        check_value("retired", 32'(retired), 32'h0);
        @(posedge clk);
        #10;
        check_regs();

        for (i = 0; i < n_entries; i++) begin
            issue_word(tbl[i].word);
            if (tbl[i].chk || tbl[i].full || tbl[i].lat != 0) begin
                wait_idle();
                if (tbl[i].chk) begin
                    dbg_addr = tbl[i].word[27:24];
                    @(negedge clk);
                    check_value($sformatf("dbg_data r%0d", tbl[i].word[27:24]), dbg_data,
                                tbl[i].exp);
                    @(posedge clk);
                    #10;
                end
                if (tbl[i].full)
                    check_regs();
            end
        end

        wait_idle();
        // every accepted id retired once
        check_value("accepted count", 32'(n_acc), 32'(n_entries));
        check_value("retired count", 32'(n_ret), 32'(n_entries));

        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: flist.f
+incdir+source
source/core_types_pkg.sv
source/wb_types_pkg.sv
source/wb_interfaces.sv
source/issue_stage.sv
source/alu_unit.sv
source/mul_unit.sv
source/write_back.sv
source/register_file.sv
source/wb_subsystem.sv
test/wb_subsystem_tb.sv
